/* verilog/decoder_cfg.svh */
`ifndef DECODER_CFG_SVH
`define DECODER_CFG_SVH

// word and field widths
`define DATA_W  16
`define FIELD_W 4
`define PSR_W   5

// primary opcodes, bits 15:12
`define OP_RTYPE 4'b0000
`define OP_ANDI  4'b0001
`define OP_ORI   4'b0010
`define OP_XORI  4'b0011
`define OP_MEM   4'b0100
`define OP_ADDI  4'b0101
`define OP_ADDUI 4'b0110
`define OP_SHIFT 4'b1000
`define OP_SUBI  4'b1001
`define OP_CMPI  4'b1011
`define OP_BCOND 4'b1100
`define OP_MOVI  4'b1101
`define OP_LUI   4'b1111

// sub-opcodes, bits 7:4
`define EXT_CMP   4'b1011
`define EXT_LSH   4'b0100
`define EXT_LOAD  4'b0000
`define EXT_STOR  4'b0100
`define EXT_JCOND 4'b1100

// condition codes in the destination field of jumps and branches
`define COND_EQ  4'b0000
`define COND_NEQ 4'b0001
`define COND_CS  4'b0010
`define COND_CC  4'b0011
`define COND_HI  4'b0100
`define COND_LS  4'b0101
`define COND_GT  4'b0110
`define COND_LEQ 4'b0111
`define COND_FS  4'b1000
`define COND_FC  4'b1001
`define COND_LO  4'b1010
`define COND_HS  4'b1011
`define COND_LT  4'b1100
`define COND_GEQ 4'b1101
`define COND_UC  4'b1110
`define COND_NV  4'b1111

// rewrite targets
`define ADDU_EXT 4'b0110
`define ADDI_OP  4'b0101

// or r0,r0 into r0
`define NOP_WORD 16'b0000_0000_0010_0000

`endif

/* verilog/decoderPkg.sv */
`include "decoder_cfg.svh"

package decoderPkg;

    // register-register view
    // opcode | rdest | ext | rsrc
    typedef struct packed {
        logic [`FIELD_W-1:0] opcode;
        logic [`FIELD_W-1:0] dest;
        logic [`FIELD_W-1:0] ext;
        logic [`FIELD_W-1:0] src;
    } regView_t;

    // immediate view
    // opcode | rdest or cond | imm8 or disp8
    typedef struct packed {
        logic [`FIELD_W-1:0]            opcode;
        logic [`FIELD_W-1:0]            destCond;
        logic [`DATA_W-2*`FIELD_W-1:0] imm;
    } immView_t;

    // same 16 bits decoded either way
    typedef union packed {
        regView_t r;
        immView_t i;
    } instrWord_t;

    // instruction class after opcode decode
    typedef enum logic [3:0] {
        // reg-reg alu op
        rType,
        // cmp writes psr only
        compare,
        // lsh
        shiftReg,
        // lshi
        shiftImm,
        // addi, addui, subi
        arithImm,
        // cmpi
        compareImm,
        // andi, ori, xori, movi
        logicImm,
        // lui
        upperImm,
        load,
        store,
        // jcond through a register
        jump,
        // bcond with pc relative displacement
        branch,
        // empty word or unused encoding
        nop
    } opClass_t;

    // how the immediate is widened for the alu
    typedef enum logic [1:0] {
        // taken as is
        immRaw  = 2'd0,
        // sign extended
        immSign = 2'd1,
        // zero extended
        immZero = 2'd2,
        // no immediate so the alu adds zero
        immNone = 2'd3
    } immType_t;

    // bit positions in the psr
    localparam int negFlag   = 4;
    localparam int zeroFlag  = 3;
    localparam int flagSet   = 2;
    localparam int lowFlag   = 1;
    localparam int carryFlag = 0;

endpackage

/* verilog/conditionEval.sv */
`timescale 1ns/1ns
`include "decoder_cfg.svh"

module conditionEval
    import decoderPkg::*;
(
    input  logic [`FIELD_W-1:0] cond,
    input  logic [`PSR_W-1:0]   psr,
    output logic                condMet
);

    // flag aliases
    logic n;
    logic z;
    logic f;
    logic l;
    logic c;

    assign n = psr[negFlag];
    assign z = psr[zeroFlag];
    assign f = psr[flagSet];
    assign l = psr[lowFlag];
    assign c = psr[carryFlag];

    // one table for both jcond and bcond
    always_comb begin
        case (cond)
            // zero flag
            `COND_EQ:  condMet = z;
            `COND_NEQ: condMet = ~z;

            // signed compare where N set means greater
            `COND_GT:  condMet = n;
            // greater or equal taken as N or Z for both jumps and branches
            `COND_GEQ: condMet = n | z;
            `COND_LT:  condMet = ~n & ~z;
            `COND_LEQ: condMet = ~n;

            // carry
            `COND_CS:  condMet = c;
            `COND_CC:  condMet = ~c;

            // unsigned compare where L set means higher
            `COND_HI:  condMet = l;
            `COND_HS:  condMet = l | z;
            `COND_LS:  condMet = ~l;
            `COND_LO:  condMet = ~l & ~z;

            // user flag
            `COND_FS:  condMet = f;
            `COND_FC:  condMet = ~f;

            // always
            `COND_UC:  condMet = 1'b1;

            // never and anything unknown
            `COND_NV:  condMet = 1'b0;
            default:   condMet = 1'b0;
        endcase
    end

endmodule

/* verilog/instructionRewrite.sv */
`timescale 1ns/1ns
`include "decoder_cfg.svh"

module instructionRewrite
    import decoderPkg::*;
(
    input  instrWord_t instruction,
    input  opClass_t   opClass,
    input  logic       condMet,
    output instrWord_t rewritten
);

    always_comb begin
        // most classes go to execute unchanged
        rewritten = instruction;

        case (opClass)
            load: begin
                // addu rdest, rsrc
                // alu adds zero to the address register
                rewritten.r.opcode = `OP_RTYPE;
                rewritten.r.dest   = instruction.r.dest;
                rewritten.r.ext    = `ADDU_EXT;
                rewritten.r.src    = instruction.r.src;
            end

            store: begin
                // address register moves to src
                // data register moves to dest
                rewritten.r.opcode = `OP_RTYPE;
                rewritten.r.dest   = instruction.r.src;
                rewritten.r.ext    = `ADDU_EXT;
                rewritten.r.src    = instruction.r.dest;
            end

            jump: begin
                if (condMet) begin
                    // addu r0, rtarget
                    // pc gets the target register
                    rewritten.r.opcode = `OP_RTYPE;
                    rewritten.r.dest   = '0;
                    rewritten.r.ext    = `ADDU_EXT;
                    rewritten.r.src    = instruction.r.src;
                end else begin
                    rewritten = `NOP_WORD;
                end
            end

            branch: begin
                if (condMet) begin
                    // addi r0, disp
                    // pc comes in on the other operand
                    rewritten.i.opcode   = `ADDI_OP;
                    rewritten.i.destCond = '0;
                    rewritten.i.imm      = instruction.i.imm;
                end else begin
                    rewritten = `NOP_WORD;
                end
            end

            nop: begin
                // empty word or unused mem sub-op
                rewritten = `NOP_WORD;
            end

            default: begin
                // alu classes pass straight through
                rewritten = instruction;
            end
        endcase
    end

endmodule

/* verilog/decodeControl.sv */
`timescale 1ns/1ns
`include "decoder_cfg.svh"

module decodeControl
    import decoderPkg::*;
(
    input  logic                clk,
    input  logic                reset,
    input  instrWord_t          instruction,
    input  logic                condMet,
    input  instrWord_t          rewritten,
    output opClass_t            opClass,
    output logic                ramWriteEnable,
    output logic                regWriteEnable,
    output logic                pcWrite,
    output logic                operandFromPc,
    output logic                immSelect,
    output immType_t            immType,
    output logic                writeBackFromAlu,
    output logic [`FIELD_W-1:0] regWriteAddress,
    output instrWord_t          instructionOut
);

    // next values ahead of the pipeline register
    logic                nextRamWrite;
    logic                nextRegWrite;
    logic                nextPcWrite;
    logic                nextFromPc;
    logic                nextImmSelect;
    immType_t            nextImmType;
    logic                nextFromAlu;
    logic [`FIELD_W-1:0] nextWriteAddress;

    // opcode class
    always_comb begin
        if (instruction == '0) begin
            // all-zero word
            opClass = nop;
        end else begin
            case (instruction.r.opcode)
                `OP_RTYPE: begin
                    if (instruction.r.ext == `EXT_CMP)
                        opClass = compare;
                    else
                        opClass = rType;
                end
                `OP_SHIFT: begin
                    // lsh by register, otherwise lshi
                    if (instruction.r.ext == `EXT_LSH)
                        opClass = shiftReg;
                    else
                        opClass = shiftImm;
                end
                `OP_ADDI, `OP_ADDUI, `OP_SUBI: opClass = arithImm;
                `OP_CMPI:                      opClass = compareImm;
                `OP_ANDI, `OP_ORI, `OP_XORI, `OP_MOVI: begin
                    opClass = logicImm;
                end
                `OP_LUI: opClass = upperImm;
                `OP_MEM: begin
                    // sub-op picks load, store or jump
                    case (instruction.r.ext)
                        `EXT_LOAD:  opClass = load;
                        `EXT_STOR:  opClass = store;
                        `EXT_JCOND: opClass = jump;
                        default:    opClass = nop;
                    endcase
                end
                `OP_BCOND: opClass = branch;
                default:   opClass = nop;
            endcase
        end
    end

    // control lines per class
    always_comb begin
        nextRamWrite  = 1'b0;
        nextRegWrite  = 1'b0;
        nextPcWrite   = 1'b0;
        nextFromPc    = 1'b0;
        nextImmSelect = 1'b0;
        nextImmType   = immRaw;
        nextFromAlu   = 1'b1;

        case (opClass)
            rType, shiftReg: begin
                nextRegWrite = 1'b1;
            end
            shiftImm, upperImm: begin
                // shift amount or upper byte used raw
                nextRegWrite  = 1'b1;
                nextImmSelect = 1'b1;
                nextImmType   = immRaw;
            end
            arithImm: begin
                nextRegWrite  = 1'b1;
                nextImmSelect = 1'b1;
                nextImmType   = immSign;
            end
            compareImm: begin
                // psr update only
                nextImmSelect = 1'b1;
                nextImmType   = immSign;
            end
            logicImm: begin
                nextRegWrite  = 1'b1;
                nextImmSelect = 1'b1;
                nextImmType   = immZero;
            end
            load: begin
                // result comes back from ram, not the alu
                nextRegWrite  = 1'b1;
                nextImmSelect = 1'b1;
                nextImmType   = immNone;
                nextFromAlu   = 1'b0;
            end
            store: begin
                nextRamWrite = 1'b1;
            end
            jump: begin
                if (condMet) begin
                    nextPcWrite   = 1'b1;
                    nextImmSelect = 1'b1;
                    nextImmType   = immNone;
                end
            end
            branch: begin
                if (condMet) begin
                    // pc plus sign extended displacement
                    nextPcWrite   = 1'b1;
                    nextFromPc    = 1'b1;
                    nextImmSelect = 1'b1;
                    nextImmType   = immSign;
                end
            end
            // compare and nop keep the defaults
            default: begin
                nextRegWrite = 1'b0;
            end
        endcase
    end

    // write address only meaningful with a write
    assign nextWriteAddress = nextRegWrite ? instruction.r.dest : '0;

    // decode stage pipeline register
    always_ff @(posedge clk) begin
        if (reset) begin
            ramWriteEnable   <= 1'b0;
            regWriteEnable   <= 1'b0;
            pcWrite          <= 1'b0;
            operandFromPc    <= 1'b0;
            immSelect        <= 1'b0;
            immType          <= immRaw;
            writeBackFromAlu <= 1'b1;
            regWriteAddress  <= '0;
            instructionOut   <= `NOP_WORD;
        end else begin
            ramWriteEnable   <= nextRamWrite;
            regWriteEnable   <= nextRegWrite;
            pcWrite          <= nextPcWrite;
            operandFromPc    <= nextFromPc;
            immSelect        <= nextImmSelect;
            immType          <= nextImmType;
            writeBackFromAlu <= nextFromAlu;
            regWriteAddress  <= nextWriteAddress;
            instructionOut   <= rewritten;
        end
    end

endmodule

/* verilog/decoderTop.sv */
`timescale 1ns/1ns
`include "decoder_cfg.svh"

module decoderTop
    import decoderPkg::*;
(
    input  logic                clk,
    input  logic                reset,
    input  instrWord_t          instruction,
    input  logic [`PSR_W-1:0]   psr,
    output logic                ramWriteEnable,
    output logic                regWriteEnable,
    output logic                pcWrite,
    output logic                operandFromPc,
    output logic                immSelect,
    output immType_t            immType,
    output logic                writeBackFromAlu,
    output logic [`FIELD_W-1:0] regWriteAddress,
    output instrWord_t          instructionOut
);

    // class from the control block
    opClass_t   opClass;
    // shared condition result for jumps and branches
    logic       condMet;
    // word handed to execute before the register
    instrWord_t rewritten;

    // condition sits where the destination register would be
    conditionEval i_conditionEval (
        .cond    (instruction.i.destCond),
        .psr     (psr),
        .condMet (condMet)
    );

    // load, store, jump and branch turned into alu ops
    instructionRewrite i_instructionRewrite (
        .instruction (instruction),
        .opClass     (opClass),
        .condMet     (condMet),
        .rewritten   (rewritten)
    );

    // classify, form controls, register everything
    decodeControl i_decodeControl (
        .clk              (clk),
        .reset            (reset),
        .instruction      (instruction),
        .condMet          (condMet),
        .rewritten        (rewritten),
        .opClass          (opClass),
        .ramWriteEnable   (ramWriteEnable),
        .regWriteEnable   (regWriteEnable),
        .pcWrite          (pcWrite),
        .operandFromPc    (operandFromPc),
        .immSelect        (immSelect),
        .immType          (immType),
        .writeBackFromAlu (writeBackFromAlu),
        .regWriteAddress  (regWriteAddress),
        .instructionOut   (instructionOut)
    );

endmodule

/* sim/clockGen.sv */
`timescale 1ns/1ns

module clockGen (
    output logic clk,
    output logic reset
);

    // 40 ns period
    localparam int halfPeriod  = 20;
    localparam int resetCycles = 4;

    initial begin
        clk = 1'b0;
        forever #(halfPeriod) clk = ~clk;
    end

    // released on a falling edge away from the sampling edge
    initial begin
        reset = 1'b1;
        repeat (resetCycles) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

/* sim/decoderTb.sv */
`timescale 1ns/1ns
`include "decoder_cfg.svh"

module decoderTb
    import decoderPkg::*;
();

    // reset and directed words plus one sweep each for jump and branch
    localparam int directedCycles = 64 + 2 * 16 * 32;
    localparam int randomCycles   = 256;
    localparam int cycleLimit     = directedCycles + randomCycles + 20;

    // expected control lines in port order
    typedef struct packed {
        logic       ramWrite;
        logic       regWrite;
        logic       pcWrite;
        logic       fromPc;
        logic       immSel;
        logic [1:0] immType;
        logic       fromAlu;
        logic [3:0] writeAddr;
    } control_t;

    logic                clk;
    logic                reset;
    instrWord_t          instruction;
    logic [`PSR_W-1:0]   psr;
    logic                ramWriteEnable;
    logic                regWriteEnable;
    logic                pcWrite;
    logic                operandFromPc;
    logic                immSelect;
    immType_t            immType;
    logic                writeBackFromAlu;
    logic [`FIELD_W-1:0] regWriteAddress;
    instrWord_t          instructionOut;

    // inputs as seen by the last rising edge
    logic [15:0] prevWord;
    logic [4:0]  prevFlags;
    logic        prevReset;
    // word whose result is checked next
    string       pendingName;
    int          cycleCount = 0;
    integer      seed = 32'h0016db2b;
    logic [31:0] randomWord;
    logic [31:0] randomFlags;
    logic [15:0] classWords [15];
    logic [15:0] nopWords [6];

    clockGen i_clockGen (.clk(clk), .reset(reset));

    decoderTop i_decoderTop (.*);

    // inputs only move on falling edges so this capture sees settled values
    always @(posedge clk) begin
        prevWord   <= instruction;
        prevFlags  <= psr;
        prevReset  <= reset;
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("timeout, decoder run still going after %0d cycles", cycleLimit);
            $display("sim failed");
            $fatal(1, "timeout");
        end
    end

    task automatic reportMismatch(input string testName, input string what,
                                  input logic [15:0] expected, input logic [15:0] actual);
        $display("FAILED %s %s expected 0x%h actual 0x%h", testName, what, expected, actual);
        $display("sim failed");
        $fatal(1, "decoder output mismatch");
    endtask

    // N Z F L C rules shared by jumps and branches
    function automatic logic conditionHolds(input logic [3:0] cond, input logic [4:0] flags);
        case (cond)
            `COND_EQ:  return flags[zeroFlag];
            `COND_NEQ: return !flags[zeroFlag];
            `COND_GT:  return flags[negFlag];
            `COND_GEQ: return flags[negFlag] | flags[zeroFlag];
            `COND_LT:  return !flags[negFlag] & !flags[zeroFlag];
            `COND_LEQ: return !flags[negFlag];
            `COND_CS:  return flags[carryFlag];
            `COND_CC:  return !flags[carryFlag];
            `COND_HI:  return flags[lowFlag];
            `COND_HS:  return flags[lowFlag] | flags[zeroFlag];
            `COND_LS:  return !flags[lowFlag];
            `COND_LO:  return !flags[lowFlag] & !flags[zeroFlag];
            `COND_FS:  return flags[flagSet];
            `COND_FC:  return !flags[flagSet];
            `COND_UC:  return 1'b1;
            // never
            default:   return 1'b0;
        endcase
    endfunction

    // class table, condition and rewrite rules
    function automatic control_t referenceOutputs(input logic rst, input logic [15:0] word,
                                                  input logic [4:0] flags,
                                                  output logic [15:0] wordOut);
        control_t   e;
        logic [3:0] op;
        logic [3:0] dst;
        logic [3:0] ext;
        logic [3:0] src;
        logic       taken;
        {op, dst, ext, src} = word;
        taken = conditionHolds(dst, flags);
        e = '0;
        e.fromAlu = 1'b1;
        wordOut = word;
        if (rst || word == '0) begin
            wordOut = `NOP_WORD;
        end else begin
            case (op)
                `OP_RTYPE: e.regWrite = (ext != `EXT_CMP);
                // lshi takes its amount raw
                `OP_SHIFT: {e.regWrite, e.immSel} = {1'b1, ext != `EXT_LSH};
                `OP_ADDI, `OP_ADDUI, `OP_SUBI: begin
                    {e.regWrite, e.immSel, e.immType} = {2'b11, immSign};
                end
                `OP_CMPI: {e.immSel, e.immType} = {1'b1, immSign};
                `OP_ANDI, `OP_ORI, `OP_XORI, `OP_MOVI: begin
                    {e.regWrite, e.immSel, e.immType} = {2'b11, immZero};
                end
                `OP_LUI: {e.regWrite, e.immSel} = 2'b11;
                `OP_MEM: begin
                    case (ext)
                        `EXT_LOAD: begin
                            {e.regWrite, e.immSel, e.fromAlu} = 3'b110;
                            e.immType = immNone;
                            wordOut   = {`OP_RTYPE, dst, `ADDU_EXT, src};
                        end
                        `EXT_STOR: begin
                            // data and address registers trade places
                            e.ramWrite = 1'b1;
                            wordOut    = {`OP_RTYPE, src, `ADDU_EXT, dst};
                        end
                        `EXT_JCOND: begin
                            {e.pcWrite, e.immSel} = {taken, taken};
                            e.immType = taken ? immNone : immRaw;
                            wordOut   = taken ? {`OP_RTYPE, 4'h0, `ADDU_EXT, src} : `NOP_WORD;
                        end
                        default: wordOut = `NOP_WORD;
                    endcase
                end
                `OP_BCOND: begin
                    {e.pcWrite, e.fromPc, e.immSel} = {3{taken}};
                    e.immType = taken ? immSign : immRaw;
                    wordOut   = taken ? {`ADDI_OP, 4'h0, word[7:0]} : `NOP_WORD;
                end
                default: wordOut = `NOP_WORD;
            endcase
        end
        e.writeAddr = e.regWrite ? dst : 4'h0;
        return e;
    endfunction

    // outputs now hold the result of the word from one rising edge back
    task automatic checkOutputs(input string testName);
        control_t    expControl;
        control_t    actControl;
        logic [15:0] expWord;
        expControl = referenceOutputs(prevReset, prevWord, prevFlags, expWord);
        actControl = {ramWriteEnable, regWriteEnable, pcWrite, operandFromPc, immSelect,
                      immType, writeBackFromAlu, regWriteAddress};
        assert (actControl === expControl)
            else reportMismatch(testName, "controls", expControl, actControl);
        assert (instructionOut === expWord)
            else reportMismatch(testName, "instructionOut", expWord, instructionOut);
    endtask

    // check the previous word, then drive the next one
    task automatic applyWord(input string name, input logic [15:0] word,
                             input logic [4:0] flags);
        @(negedge clk);
        checkOutputs(pendingName);
        instruction = word;
        psr         = flags;
        pendingName = name;
    endtask

    initial begin
        instruction = 16'h4A03;
        psr         = '1;
        pendingName = "reset";
        // add, cmp, lsh, lshi, addi, addui, subi, cmpi, andi, ori, xori, movi, lui, load, stor
        classWords = '{16'h0352, 16'h04B1, 16'h8647, 16'h8603, 16'h5A80, 16'h6B7F, 16'h9C01,
                       16'hB2FF, 16'h1F0F, 16'h2E33, 16'h3D55, 16'hD1AA, 16'hF712, 16'h4A03,
                       16'h4B47};
        // zero word, unused mem sub-ops, unused opcodes
        nopWords = '{16'h0000, 16'h4510, 16'h4EF0, 16'h7123, 16'hA000, 16'hE555};

        // first rising edge loads the reset values
        @(posedge clk);

        // load held through reset must not reach the outputs
        repeat (6) applyWord("reset", 16'h4A03, '1);

        foreach (classWords[k]) applyWord("class", classWords[k], 5'h0A);

        // every code against every flag pattern
        for (int cond = 0; cond < 16; cond++) begin
            for (int flags = 0; flags < 32; flags++) begin
                applyWord("condJump", {`OP_MEM, cond[3:0], `EXT_JCOND, 4'h9}, flags[4:0]);
                applyWord("condBranch", {`OP_BCOND, cond[3:0], 8'hF6}, flags[4:0]);
            end
        end

        foreach (nopWords[k]) applyWord("nop", nopWords[k], 5'h1F);

        // back-to-back random words
        repeat (randomCycles) begin
            randomWord  = $random(seed);
            randomFlags = $random(seed);
            applyWord("random", randomWord[15:0], randomFlags[4:0]);
        end

        // result of the last word
        @(negedge clk);
        checkOutputs(pendingName);
        $display("sim passed");
        $finish;
    end

endmodule

/* vlog.f */
+incdir+verilog
verilog/decoderPkg.sv
verilog/conditionEval.sv
verilog/instructionRewrite.sv
verilog/decodeControl.sv
verilog/decoderTop.sv
sim/clockGen.sv
sim/decoderTb.sv
